//--- tensor_octet_pkg.sv
`default_nettype none

// shared sizes and types for the tensor octet
package tensor_octet_pkg;

    // lane word and octet geometry
    localparam int word_w = 32;
    localparam int octet_lanes = 8;
    localparam int tg_lanes = 4;

    // (m,n,k) of one multiply-accumulate
    localparam int tile_m = 4;
    localparam int tile_n = 4;
    localparam int tile_k = 2;

    typedef logic [word_w-1:0] lane_word_t;

    // one operand or one writeback beat across the octet
    typedef lane_word_t [octet_lanes-1:0] lane_vec_t;

    // one operand half, four words
    typedef lane_word_t [tg_lanes-1:0] half_vec_t;

    // tiles are indexed [row][col]
    typedef lane_word_t [tile_m-1:0][tile_k-1:0] a_tile_t;
    typedef lane_word_t [tile_k-1:0][tile_n-1:0] b_tile_t;
    typedef lane_word_t [tile_m-1:0][tile_n-1:0] acc_tile_t;

    // destination register index
    typedef logic [4:0] rd_t;

    // step of the four-step sequence, picks the operand halves
    typedef enum logic [1:0] {
        STEP_0,
        STEP_1,
        STEP_2,
        STEP_3
    } step_e;

    // which half of the result columns goes out
    typedef enum logic {
        BEAT_LOW,
        BEAT_HIGH
    } beat_e;

endpackage

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// register based FIFO, head entry shows on data_out
module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 2,
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1,
    localparam int cnt_w = $clog2(depth + 1)
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              push,
    input  wire              pop,
    input  wire  [width-1:0] data_in,
    output logic [width-1:0] data_out,
    output logic             empty,
    output logic             full
);
    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == cnt_w'(depth));

    no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
    no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

//--- operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

// input side: lane mapping, half selection and per-warp staging of first substeps
module operand_stage #(
    parameter int num_warps = 4,
    localparam int wid_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                op_valid,
    input  wire  [wid_w-1:0]                   op_wid,
    input  wire  tensor_octet_pkg::step_e      op_step,
    input  wire                                op_last,
    input  wire  tensor_octet_pkg::lane_vec_t  op_a,
    input  wire  tensor_octet_pkg::lane_vec_t  op_b,
    input  wire  tensor_octet_pkg::lane_vec_t  op_c,
    input  wire                                mac_ready,
    input  wire                                meta_full,
    output logic                               op_ready,
    output logic                               op_accept,
    output logic                               mac_valid,
    output tensor_octet_pkg::a_tile_t          mac_a,
    output tensor_octet_pkg::b_tile_t          mac_b,
    output tensor_octet_pkg::acc_tile_t        mac_c,
    output logic [wid_w-1:0]                   mac_wid
);
    tensor_octet_pkg::half_vec_t a_cur;
    tensor_octet_pkg::half_vec_t b_cur;
    tensor_octet_pkg::half_vec_t a_buf [num_warps];
    tensor_octet_pkg::half_vec_t b_buf [num_warps];
    tensor_octet_pkg::lane_vec_t c_buf [num_warps];
    tensor_octet_pkg::half_vec_t a_st;
    tensor_octet_pkg::half_vec_t b_st;
    tensor_octet_pkg::lane_vec_t c_st;
    logic [num_warps-1:0] staged;

    // metadata queue and pipe must both take the substep
    assign op_ready = mac_ready && !meta_full;
    assign op_accept = op_valid && op_ready;
    assign mac_valid = op_valid && op_last && !meta_full;
    assign mac_wid = op_wid;

    // A columns alternate per step, B rows switch after step 1
    always_comb begin
        case (op_step)
            tensor_octet_pkg::STEP_0, tensor_octet_pkg::STEP_2: begin
                a_cur = {op_a[5], op_a[4], op_a[1], op_a[0]};
            end
            default: begin
                a_cur = {op_a[7], op_a[6], op_a[3], op_a[2]};
            end
        endcase
        case (op_step)
            tensor_octet_pkg::STEP_0, tensor_octet_pkg::STEP_1: b_cur = op_b[3:0];
            default: b_cur = op_b[7:4];
        endcase
    end

    assign a_st = a_buf[op_wid];
    assign b_st = b_buf[op_wid];
    assign c_st = c_buf[op_wid];

    // staged half is k0, current half is k1
    always_comb begin
        for (int r = 0; r < tensor_octet_pkg::tg_lanes; r++) begin
            mac_a[r][0] = a_st[r];
            mac_a[r][1] = a_cur[r];
        end
        mac_b[0] = b_st;
        mac_b[1] = b_cur;
        // each lane owns a 1x2 pair of C along the row
        mac_c[0] = {op_c[2], c_st[2], op_c[0], c_st[0]};
        mac_c[1] = {op_c[3], c_st[3], op_c[1], c_st[1]};
        mac_c[2] = {op_c[6], c_st[6], op_c[4], c_st[4]};
        mac_c[3] = {op_c[7], c_st[7], op_c[5], c_st[5]};
    end

    always_ff @(posedge clk) begin
        if (op_accept && !op_last) begin
            a_buf[op_wid] <= a_cur;
            b_buf[op_wid] <= b_cur;
            c_buf[op_wid] <= op_c;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            staged <= '0;
        end else if (op_accept) begin
            staged[op_wid] <= !op_last;
        end
    end

    pair_order: assert property (@(posedge clk) disable iff (reset)
        (op_accept && op_last) |-> staged[op_wid]);

endmodule

`default_nettype wire

//--- mac_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4x2 integer multiply-accumulate with a fixed depth that stalls as a whole on a full output
module mac_pipeline #(
    parameter int num_warps = 4,
    parameter int mac_latency = 3,
    localparam int wid_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                mac_valid,
    input  wire  tensor_octet_pkg::a_tile_t    mac_a,
    input  wire  tensor_octet_pkg::b_tile_t    mac_b,
    input  wire  tensor_octet_pkg::acc_tile_t  mac_c,
    input  wire  [wid_w-1:0]                   mac_wid,
    input  wire                                res_ready,
    output logic                               mac_ready,
    output logic                               res_valid,
    output tensor_octet_pkg::acc_tile_t        res_tile,
    output logic [wid_w-1:0]                   res_wid
);
    tensor_octet_pkg::acc_tile_t mac_d;
    tensor_octet_pkg::acc_tile_t tile_q [mac_latency];
    logic [wid_w-1:0] wid_q [mac_latency];
    logic [mac_latency-1:0] vld_q;
    logic stall;

    // D = A*B + C modulo 2^32
    always_comb begin
        for (int r = 0; r < tensor_octet_pkg::tile_m; r++) begin
            for (int c = 0; c < tensor_octet_pkg::tile_n; c++) begin
                mac_d[r][c] = mac_c[r][c];
                for (int k = 0; k < tensor_octet_pkg::tile_k; k++) begin
                    mac_d[r][c] = mac_d[r][c] + mac_a[r][k] * mac_b[k][c];
                end
            end
        end
    end

    assign stall = vld_q[mac_latency-1] && !res_ready;
    assign mac_ready = !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else if (!stall) begin
            for (int s = mac_latency - 1; s > 0; s--) begin
                vld_q[s] <= vld_q[s-1];
            end
            vld_q[0] <= mac_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int s = mac_latency - 1; s > 0; s--) begin
                tile_q[s] <= tile_q[s-1];
                wid_q[s] <= wid_q[s-1];
            end
            tile_q[0] <= mac_d;
            wid_q[0] <= mac_wid;
        end
    end

    assign res_valid = vld_q[mac_latency-1];
    assign res_tile = tile_q[mac_latency-1];
    assign res_wid = wid_q[mac_latency-1];

endmodule

`default_nettype wire

//--- writeback_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// output side: result buffer, per-warp rd queues and two-beat commit
module writeback_sequencer #(
    parameter int num_warps = 4,
    parameter int result_depth = 2,
    parameter int meta_depth = 4,
    localparam int wid_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                res_valid,
    input  wire  tensor_octet_pkg::acc_tile_t  res_tile,
    input  wire  [wid_w-1:0]                   res_wid,
    input  wire                                op_accept,
    input  wire  [wid_w-1:0]                   op_wid,
    input  wire  tensor_octet_pkg::rd_t        op_rd,
    input  wire                                commit_ready,
    output logic                               res_ready,
    output logic                               meta_full,
    output logic                               commit_valid,
    output logic [wid_w-1:0]                   commit_wid,
    output tensor_octet_pkg::rd_t              commit_rd,
    output tensor_octet_pkg::beat_e            commit_beat,
    output tensor_octet_pkg::lane_vec_t        commit_data
);
    localparam int res_w = $bits(tensor_octet_pkg::acc_tile_t) + wid_w;

    logic res_push;
    logic res_pop;
    logic res_full;
    logic res_empty;
    logic commit_fire;
    logic [res_w-1:0] res_head;
    tensor_octet_pkg::acc_tile_t head_tile;
    tensor_octet_pkg::beat_e beat_q;
    logic [num_warps-1:0] meta_fulls;
    logic [num_warps-1:0] meta_empty;
    tensor_octet_pkg::rd_t meta_rd [num_warps];

    assign res_ready = !res_full;
    assign res_push = res_valid && res_ready;
    assign commit_valid = !res_empty;
    assign commit_fire = commit_valid && commit_ready;
    // result leaves once its second beat is taken
    assign res_pop = commit_fire && (beat_q == tensor_octet_pkg::BEAT_HIGH);
    assign {commit_wid, head_tile} = res_head;

    sync_fifo #(
        .width (res_w),
        .depth (result_depth)
    ) result_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (res_push),
        .pop      (res_pop),
        .data_in  ({res_wid, res_tile}),
        .data_out (res_head),
        .empty    (res_empty),
        .full     (res_full)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_q <= tensor_octet_pkg::BEAT_LOW;
        end else if (commit_fire) begin
            beat_q <= (beat_q == tensor_octet_pkg::BEAT_LOW) ?
                tensor_octet_pkg::BEAT_HIGH : tensor_octet_pkg::BEAT_LOW;
        end
    end

    assign commit_beat = beat_q;

    // low beat takes columns 0 and 2, high beat columns 1 and 3
    always_comb begin
        int col;
        col = (beat_q == tensor_octet_pkg::BEAT_HIGH) ? 1 : 0;
        for (int t = 0; t < 2; t++) begin
            commit_data[tensor_octet_pkg::tg_lanes*t + 0] = head_tile[2*t][col];
            commit_data[tensor_octet_pkg::tg_lanes*t + 1] = head_tile[2*t+1][col];
            commit_data[tensor_octet_pkg::tg_lanes*t + 2] = head_tile[2*t][col+2];
            commit_data[tensor_octet_pkg::tg_lanes*t + 3] = head_tile[2*t+1][col+2];
        end
    end

    // separate queues keep the two rds of a warp together at commit
    for (genvar w = 0; w < num_warps; w++) begin : g_meta
        logic push_w;
        logic pop_w;

        assign push_w = op_accept && (op_wid == wid_w'(w));
        assign pop_w = commit_fire && (commit_wid == wid_w'(w));

        sync_fifo #(
            .width ($bits(tensor_octet_pkg::rd_t)),
            .depth (meta_depth)
        ) meta_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (push_w),
            .pop      (pop_w),
            .data_in  (op_rd),
            .data_out (meta_rd[w]),
            .empty    (meta_empty[w]),
            .full     (meta_fulls[w])
        );
    end

    assign commit_rd = meta_rd[commit_wid];
    assign meta_full = |meta_fulls;

    meta_no_overflow: assert property (@(posedge clk) disable iff (reset)
        op_accept |-> !meta_fulls[op_wid]);
    // every buffered result must still have its rd waiting
    meta_present: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> !meta_empty[commit_wid]);

endmodule

`default_nettype wire

//--- tensor_octet_top.sv
`timescale 1ns/1ps
`default_nettype none

// one tensor-core octet, 8 lanes in two threadgroups
module tensor_octet_top #(
    parameter int num_warps = 4,
    parameter int mac_latency = 3,
    parameter int result_depth = 2,
    parameter int meta_depth = 4,
    localparam int wid_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                op_valid,
    input  wire  [wid_w-1:0]                   op_wid,
    input  wire  tensor_octet_pkg::step_e      op_step,
    input  wire                                op_last,
    input  wire  tensor_octet_pkg::rd_t        op_rd,
    input  wire  tensor_octet_pkg::lane_vec_t  op_a,
    input  wire  tensor_octet_pkg::lane_vec_t  op_b,
    input  wire  tensor_octet_pkg::lane_vec_t  op_c,
    input  wire                                commit_ready,
    output logic                               op_ready,
    output logic                               commit_valid,
    output logic [wid_w-1:0]                   commit_wid,
    output tensor_octet_pkg::rd_t              commit_rd,
    output tensor_octet_pkg::beat_e            commit_beat,
    output tensor_octet_pkg::lane_vec_t        commit_data
);
    logic op_accept;
    logic meta_full;
    logic mac_valid;
    logic mac_ready;
    tensor_octet_pkg::a_tile_t mac_a;
    tensor_octet_pkg::b_tile_t mac_b;
    tensor_octet_pkg::acc_tile_t mac_c;
    logic [wid_w-1:0] mac_wid;
    logic res_valid;
    logic res_ready;
    tensor_octet_pkg::acc_tile_t res_tile;
    logic [wid_w-1:0] res_wid;

    operand_stage #(
        .num_warps (num_warps)
    ) operand_stage_i (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op_wid    (op_wid),
        .op_step   (op_step),
        .op_last   (op_last),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_c      (op_c),
        .mac_ready (mac_ready),
        .meta_full (meta_full),
        .op_ready  (op_ready),
        .op_accept (op_accept),
        .mac_valid (mac_valid),
        .mac_a     (mac_a),
        .mac_b     (mac_b),
        .mac_c     (mac_c),
        .mac_wid   (mac_wid)
    );

    mac_pipeline #(
        .num_warps   (num_warps),
        .mac_latency (mac_latency)
    ) mac_pipeline_i (
        .clk       (clk),
        .reset     (reset),
        .mac_valid (mac_valid),
        .mac_a     (mac_a),
        .mac_b     (mac_b),
        .mac_c     (mac_c),
        .mac_wid   (mac_wid),
        .res_ready (res_ready),
        .mac_ready (mac_ready),
        .res_valid (res_valid),
        .res_tile  (res_tile),
        .res_wid   (res_wid)
    );

    writeback_sequencer #(
        .num_warps    (num_warps),
        .result_depth (result_depth),
        .meta_depth   (meta_depth)
    ) writeback_sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .res_valid    (res_valid),
        .res_tile     (res_tile),
        .res_wid      (res_wid),
        .op_accept    (op_accept),
        .op_wid       (op_wid),
        .op_rd        (op_rd),
        .commit_ready (commit_ready),
        .res_ready    (res_ready),
        .meta_full    (meta_full),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_rd    (commit_rd),
        .commit_beat  (commit_beat),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

//--- tensor_octet_tb_model.svh
`ifndef TENSOR_OCTET_TB_MODEL_SVH
`define TENSOR_OCTET_TB_MODEL_SVH

// lane of A that feeds half index i, odd steps take the upper pair of each threadgroup
function automatic int a_lane(input tensor_octet_pkg::step_e step, input int i);
    int base;
    base = (i < 2) ? i : i + 2;
    if (step == tensor_octet_pkg::STEP_1 || step == tensor_octet_pkg::STEP_3) begin
        base = base + 2;
    end
    return base;
endfunction

// lane of B for half index i, steps 2 and 3 use the second threadgroup
function automatic int b_lane(input tensor_octet_pkg::step_e step, input int i);
    if (step == tensor_octet_pkg::STEP_0 || step == tensor_octet_pkg::STEP_1) begin
        return i;
    end
    return i + 4;
endfunction

// expected beats and rds for one pair, first substep is k0
function automatic void model_pair(
    input  tensor_octet_pkg::step_e   step0,
    input  tensor_octet_pkg::lane_vec_t a0,
    input  tensor_octet_pkg::lane_vec_t b0,
    input  tensor_octet_pkg::lane_vec_t c0,
    input  tensor_octet_pkg::rd_t     rd0,
    input  tensor_octet_pkg::step_e   step1,
    input  tensor_octet_pkg::lane_vec_t a1,
    input  tensor_octet_pkg::lane_vec_t b1,
    input  tensor_octet_pkg::lane_vec_t c1,
    input  tensor_octet_pkg::rd_t     rd1,
    output tensor_octet_pkg::lane_vec_t low,
    output tensor_octet_pkg::lane_vec_t high,
    output tensor_octet_pkg::rd_t     rd_low,
    output tensor_octet_pkg::rd_t     rd_high
);
    tensor_octet_pkg::lane_word_t a [4][2];
    tensor_octet_pkg::lane_word_t b [2][4];
    tensor_octet_pkg::lane_word_t d [4][4];
    int lane;
    int row;
    int col;
    for (int i = 0; i < 4; i++) begin
        a[i][0] = a0[3'(a_lane(step0, i))];
        a[i][1] = a1[3'(a_lane(step1, i))];
        b[0][i] = b0[3'(b_lane(step0, i))];
        b[1][i] = b1[3'(b_lane(step1, i))];
    end
    // C lanes hold column pairs, even columns come from the first substep
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            lane = (r / 2) * 4 + (r % 2) + (c / 2) * 2;
            d[r][c] = (c % 2 == 0) ? c0[3'(lane)] : c1[3'(lane)];
            d[r][c] = d[r][c] + a[r][0] * b[0][c] + a[r][1] * b[1][c];
        end
    end
    for (int l = 0; l < 8; l++) begin
        row = 2 * (l / 4) + (l % 2);
        col = 2 * ((l % 4) / 2);
        low[3'(l)] = d[row][col];
        high[3'(l)] = d[row][col + 1];
    end
    rd_low = rd0;
    rd_high = rd1;
endfunction

`endif

//--- tensor_octet_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the tensor octet, pairs of substeps in and checked beats out
module tensor_octet_top_tb;
    localparam int wid_w = 2;

    logic clk = 1'b0;
    logic reset;
    logic op_valid;
    logic [wid_w-1:0] op_wid;
    tensor_octet_pkg::step_e op_step;
    logic op_last;
    tensor_octet_pkg::rd_t op_rd;
    tensor_octet_pkg::lane_vec_t op_a;
    tensor_octet_pkg::lane_vec_t op_b;
    tensor_octet_pkg::lane_vec_t op_c;
    logic commit_ready;
    logic op_ready;
    logic commit_valid;
    logic [wid_w-1:0] commit_wid;
    tensor_octet_pkg::rd_t commit_rd;
    tensor_octet_pkg::beat_e commit_beat;
    tensor_octet_pkg::lane_vec_t commit_data;

    // first substep of each warp, waiting for its partner
    tensor_octet_pkg::step_e st_step [4];
    tensor_octet_pkg::lane_vec_t st_a [4];
    tensor_octet_pkg::lane_vec_t st_b [4];
    tensor_octet_pkg::lane_vec_t st_c [4];
    tensor_octet_pkg::rd_t st_rd [4];

    // expected results in second-substep order
    tensor_octet_pkg::lane_vec_t exp_low_q [$];
    tensor_octet_pkg::lane_vec_t exp_high_q [$];
    tensor_octet_pkg::rd_t exp_rd_low_q [$];
    tensor_octet_pkg::rd_t exp_rd_high_q [$];
    logic [wid_w-1:0] exp_wid_q [$];

    string test_name = "reset";
    int checks = 0;
    int mismatches = 0;
    int other_errors = 0;
    int pushed = 0;
    int committed = 0;
    logic random_ready = 1'b0;
    logic ready_dropped = 1'b0;
    logic beat_phase;
    logic hold_pending;
    tensor_octet_pkg::lane_vec_t hold_data;
    tensor_octet_pkg::rd_t hold_rd;

    `include "tensor_octet_tb_model.svh"

    tensor_octet_top #(
        .num_warps    (4),
        .mac_latency  (3),
        .result_depth (2),
        .meta_depth   (4)
    ) tensor_octet_top_i (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .op_wid       (op_wid),
        .op_step      (op_step),
        .op_last      (op_last),
        .op_rd        (op_rd),
        .op_a         (op_a),
        .op_b         (op_b),
        .op_c         (op_c),
        .commit_ready (commit_ready),
        .op_ready     (op_ready),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_rd    (commit_rd),
        .commit_beat  (commit_beat),
        .commit_data  (commit_data)
    );

    always #2 clk = ~clk;

    task automatic expect_equal(input string name, input logic [255:0] expected,
                                input logic [255:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic tensor_octet_pkg::lane_vec_t random_vec();
        tensor_octet_pkg::lane_vec_t v;
        for (int l = 0; l < 8; l++) begin
            v[l] = $urandom();
        end
        return v;
    endfunction

    // holds the substep until op_ready, then books it as staged or expected
    task automatic send_substep(input logic [1:0] wid, input logic [1:0] step,
                                input logic last, input tensor_octet_pkg::rd_t rd);
        tensor_octet_pkg::lane_vec_t low;
        tensor_octet_pkg::lane_vec_t high;
        tensor_octet_pkg::rd_t rd_low;
        tensor_octet_pkg::rd_t rd_high;
        int waited;
        bit done;
        op_valid = 1'b1;
        op_wid = wid;
        op_step = tensor_octet_pkg::step_e'(step);
        op_last = last;
        op_rd = rd;
        op_a = random_vec();
        op_b = random_vec();
        op_c = random_vec();
        waited = 0;
        done = 1'b0;
        while (!done && waited < 200) begin
            @(negedge clk);
            if (op_ready && last) begin
                model_pair(st_step[wid], st_a[wid], st_b[wid], st_c[wid], st_rd[wid],
                           op_step, op_a, op_b, op_c, rd, low, high, rd_low, rd_high);
                exp_low_q.push_back(low);
                exp_high_q.push_back(high);
                exp_rd_low_q.push_back(rd_low);
                exp_rd_high_q.push_back(rd_high);
                exp_wid_q.push_back(wid);
                pushed++;
                done = 1'b1;
            end else if (op_ready) begin
                st_step[wid] = op_step;
                st_a[wid] = op_a;
                st_b[wid] = op_b;
                st_c[wid] = op_c;
                st_rd[wid] = rd;
                done = 1'b1;
            end else begin
                ready_dropped = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            $display("timeout: substep of warp %0d not accepted in %0d cycles", wid, waited);
            other_errors++;
        end
    endtask

    task automatic send_pair(input logic [1:0] wid, input logic [1:0] step);
        send_substep(wid, step, 1'b0, 5'($urandom()));
        send_substep(wid, step, 1'b1, 5'($urandom()));
    endtask

    task automatic wait_drain();
        int waited;
        op_valid = 1'b0;
        waited = 0;
        while ((exp_wid_q.size() != 0 || commit_valid) && waited < 1000) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_wid_q.size() != 0) begin
            $display("timeout: %0d results still missing in %s", exp_wid_q.size(), test_name);
            other_errors++;
        end
    endtask

    // one beat transfer against the head of the expected queues
    task automatic compare_beat();
        if (exp_wid_q.size() == 0) begin
            $display("commit seen in %s with no accepted second substep waiting", test_name);
            other_errors++;
        end else if (!beat_phase) begin
            expect_equal({test_name, "/wid"}, 256'(exp_wid_q[0]), 256'(commit_wid));
            expect_equal({test_name, "/beat"}, 256'(tensor_octet_pkg::BEAT_LOW),
                         256'(commit_beat));
            expect_equal({test_name, "/low_data"}, exp_low_q[0], commit_data);
            expect_equal({test_name, "/low_rd"}, 256'(exp_rd_low_q[0]), 256'(commit_rd));
            beat_phase = 1'b1;
        end else begin
            expect_equal({test_name, "/wid"}, 256'(exp_wid_q[0]), 256'(commit_wid));
            expect_equal({test_name, "/beat"}, 256'(tensor_octet_pkg::BEAT_HIGH),
                         256'(commit_beat));
            expect_equal({test_name, "/high_data"}, exp_high_q[0], commit_data);
            expect_equal({test_name, "/high_rd"}, 256'(exp_rd_high_q[0]), 256'(commit_rd));
            void'(exp_wid_q.pop_front());
            void'(exp_low_q.pop_front());
            void'(exp_high_q.pop_front());
            void'(exp_rd_low_q.pop_front());
            void'(exp_rd_high_q.pop_front());
            committed++;
            beat_phase = 1'b0;
        end
    endtask

    // commit side sink, random when back-pressure is on
    initial begin
        commit_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            commit_ready = random_ready ? (($urandom() % 3) == 0) : 1'b1;
        end
    end

    // compare process, samples mid-cycle where everything is settled
    initial begin
        beat_phase = 1'b0;
        hold_pending = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                expect_equal("reset/commit_valid", '0, 256'(commit_valid));
            end else begin
                if (hold_pending) begin
                    expect_equal({test_name, "/hold_valid"}, 256'(1), 256'(commit_valid));
                    expect_equal({test_name, "/hold_data"}, hold_data, commit_data);
                    expect_equal({test_name, "/hold_rd"}, 256'(hold_rd), 256'(commit_rd));
                end
                if (commit_valid && commit_ready) begin
                    compare_beat();
                end
                hold_pending = commit_valid && !commit_ready;
                hold_data = commit_data;
                hold_rd = commit_rd;
            end
        end
    end

    initial begin
        void'($urandom(32'hbff8_8605));
        reset = 1'b1;
        op_valid = 1'b0;
        op_wid = '0;
        op_step = tensor_octet_pkg::STEP_0;
        op_last = 1'b0;
        op_rd = '0;
        op_a = '0;
        op_b = '0;
        op_c = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        expect_equal("reset/idle_commit_valid", '0, 256'(commit_valid));

        test_name = "single_pair";
        for (int s = 0; s < 4; s++) begin
            send_pair(2'd0, 2'(s));
            wait_drain();
        end

        // first substeps of all warps, then the partners out of order
        test_name = "interleaved";
        for (int w = 0; w < 4; w++) begin
            send_substep(2'(w), 2'($urandom()), 1'b0, 5'($urandom()));
        end
        send_substep(2'd2, st_step[2], 1'b1, 5'($urandom()));
        send_substep(2'd0, st_step[0], 1'b1, 5'($urandom()));
        send_substep(2'd3, st_step[3], 1'b1, 5'($urandom()));
        send_substep(2'd1, st_step[1], 1'b1, 5'($urandom()));
        wait_drain();

        test_name = "stream";
        for (int i = 0; i < 12; i++) begin
            send_pair(2'(i), 2'($urandom()));
        end
        wait_drain();

        test_name = "backpressure";
        random_ready = 1'b1;
        ready_dropped = 1'b0;
        for (int i = 0; i < 16; i++) begin
            send_pair(2'(i), 2'($urandom()));
        end
        wait_drain();
        expect_equal("backpressure/op_ready_dropped", 256'(1), 256'(ready_dropped));
        random_ready = 1'b0;

        expect_equal("total/result_count", 256'(pushed), 256'(committed));
        $display("summary: %0d checks, %0d mismatches, %0d other errors, %0d of %0d results",
                 checks, mismatches, other_errors, committed, pushed);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tensor_octet_top.f
+incdir+.
tensor_octet_pkg.sv
sync_fifo.sv
operand_stage.sv
mac_pipeline.sv
writeback_sequencer.sv
tensor_octet_top.sv
tensor_octet_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the tensor octet testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tensor_octet_top.f \
        --top-module tensor_octet_top_tb -o tensor_octet_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tensor_octet_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
